// ==== include/l1_ld_defs.svh ====
// --------------------
// Size macros for the L1 load-side lookup path
// Address split, line geometry and array depth
// Include wherever a width or depth is needed
// --------------------
`ifndef L1_LD_DEFS_SVH
`define L1_LD_DEFS_SVH

// Full load address
`define L1_LD_ADDR_WIDTH   32

// Address split, tag | index | offset
`define L1_LD_OFFSET_WIDTH 4
`define L1_LD_INDEX_WIDTH  6
`define L1_LD_TAG_WIDTH    22

// Line geometry, 16 bytes as four words
`define L1_LD_WORD_WIDTH   32
`define L1_LD_LINE_WORDS   4

// Number of lines in each array
`define L1_LD_DEPTH        64

`endif

// ==== src/l1_ld_pkg.sv ====
// --------------------
// Shared types of the L1 load path
// Address fields, tag entry, cache line, clear state
// Import with a wildcard in the module header
// --------------------
`include "l1_ld_defs.svh"

package l1_ld_pkg;

	// --------------------
	// Load and fill address fields
	// --------------------
	typedef struct packed {
		logic [`L1_LD_TAG_WIDTH-1:0]    tag;
		logic [`L1_LD_INDEX_WIDTH-1:0]  index;
		logic [`L1_LD_OFFSET_WIDTH-1:0] offset;
	} ld_addr_t;

	// --------------------
	// Tag array entry
	// --------------------
	// All zeros reads as an invalid line
	typedef struct packed {
		logic                        valid;
		logic [`L1_LD_TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	// Word 0 sits in the lowest bits
	typedef logic [`L1_LD_LINE_WORDS-1:0][`L1_LD_WORD_WIDTH-1:0] line_t;

	// --------------------
	// Array clear sequencer
	// --------------------
	typedef enum logic {
		MEM_CLEARING = 1'b0,
		MEM_READY    = 1'b1
	} mem_state_t;

endpackage

// ==== src/l1_ld_mem_if.sv ====
// --------------------
// Port bundle of one cache array
// Read, write and ready signals
// mem side for the array, user side for lookup
// --------------------
`timescale 1ns/1ps
`include "l1_ld_defs.svh"

interface l1_ld_mem_if #(
	parameter int WIDTH = 32,
	parameter int DEPTH = `L1_LD_DEPTH
);

	localparam int AW = $clog2(DEPTH);

	// Read port, driven from the load side
	logic             ren;
	logic [AW-1:0]    raddr;
	logic [WIDTH-1:0] rdata;

	// Write port, driven from the fill side
	logic             wen;
	logic [AW-1:0]    waddr;
	logic [WIDTH-1:0] wdata;

	// High once the array has been cleared
	logic             ready;

	// Array side
	modport mem (
		input  ren, raddr, wen, waddr, wdata,
		output rdata, ready
	);

	// Lookup side, read result and status only
	modport user (
		input  rdata, ready
	);

endinterface

// ==== src/sram_dp.sv ====
// --------------------
// Behavioral two-port synchronous RAM
// One write port, one registered read port
// Read during write to the same address gives old data
// --------------------
`timescale 1ns/1ps

module sram_dp #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
) (
	input  logic                     CLK,
	// Write port
	input  logic                     wen,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  logic [WIDTH-1:0]         wdata,
	// Read port
	input  logic                     ren,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output logic [WIDTH-1:0]         rdata
);

	// Storage
	logic [WIDTH-1:0] ram [DEPTH];

	// --------------------
	// Write port
	// --------------------
	always_ff @(posedge CLK) begin
		if (wen) begin
			ram[waddr] <= wdata;
		end
	end

	// --------------------
	// Read port
	// --------------------
	// Nonblocking read samples the array before this edge's write
	always_ff @(posedge CLK) begin
		if (ren) begin
			rdata <= ram[raddr];
		end
	end

endmodule

// ==== src/l1_ld_dp_mem.sv ====
// --------------------
// Cache array with clear-after-reset
// Writes zeros to every entry, then raises ready
// Afterwards reads and writes go straight to the RAM
// --------------------
`timescale 1ns/1ps

module l1_ld_dp_mem
	import l1_ld_pkg::*;
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
) (
	input logic       CLK,
	input logic       RST_N,
	l1_ld_mem_if.mem  mem
);

	localparam int AW = $clog2(DEPTH);

	mem_state_t    state;
	logic [AW-1:0] clr_addr;

	// RAM write port after the clear mux
	logic             ram_wen;
	logic [AW-1:0]    ram_waddr;
	logic [WIDTH-1:0] ram_wdata;

	// --------------------
	// Clear sequencer
	// --------------------
	// Last address of the sweep ends the clear
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= MEM_CLEARING;
		end else if (state == MEM_CLEARING && clr_addr == {AW{1'b1}}) begin
			state <= MEM_READY;
		end
	end

	// One address per cycle while clearing
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			clr_addr <= '0;
		end else if (state == MEM_CLEARING) begin
			clr_addr <= clr_addr + 1'b1;
		end
	end

	// Sweep owns the write port until ready
	assign ram_wen   = (state == MEM_CLEARING) ? 1'b1 : mem.wen;
	assign ram_waddr = (state == MEM_CLEARING) ? clr_addr : mem.waddr;
	assign ram_wdata = (state == MEM_CLEARING) ? '0 : mem.wdata;

	assign mem.ready = (state == MEM_READY);

	// --------------------
	// Storage
	// --------------------
	sram_dp #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) ram (
		.CLK   (CLK),
		.wen   (ram_wen),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.ren   (mem.ren),
		.raddr (mem.raddr),
		.rdata (mem.rdata)
	);

	// Sweep stays parked once ready is up
	a_clr_parked: assert property (@(posedge CLK) disable iff (!RST_N)
		(state == MEM_READY) |=> $stable(clr_addr))
		else $error("clear counter moved after ready");

endmodule

// ==== src/l1_ld_lookup.sv ====
// --------------------
// Load lookup stage
// Compares stored tag with the delayed request
// Result is valid one cycle after the request
// --------------------
`timescale 1ns/1ps
`include "l1_ld_defs.svh"

module l1_ld_lookup
	import l1_ld_pkg::*;
(
	input  logic                         CLK,
	input  logic                         RST_N,
	// Load request
	input  logic                         ld_req,
	input  ld_addr_t                     ld_addr,
	// Array read results
	l1_ld_mem_if.user                    tag,
	l1_ld_mem_if.user                    data,
	// Load result
	output logic                         ld_valid,
	output logic                         ld_hit,
	output logic [`L1_LD_WORD_WIDTH-1:0] ld_data
);

	localparam int SEL_W = $clog2(`L1_LD_LINE_WORDS);

	logic                        req_q;
	logic [`L1_LD_TAG_WIDTH-1:0] tag_q;
	logic [SEL_W-1:0]            sel_q;

	tag_entry_t entry;
	line_t      line;

	// --------------------
	// Request pipeline
	// --------------------
	// Requests before ready are dropped
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			req_q <= 1'b0;
		end else begin
			req_q <= ld_req & tag.ready & data.ready;
		end
	end

	// Address fields for the compare
	always_ff @(posedge CLK) begin
		tag_q <= ld_addr.tag;
		// Word select drops the byte bits
		sel_q <= ld_addr.offset[`L1_LD_OFFSET_WIDTH-1 -: SEL_W];
	end

	// --------------------
	// Hit and word select
	// --------------------
	assign entry = tag.rdata;
	assign line  = data.rdata;

	assign ld_valid = req_q;
	assign ld_hit   = req_q & entry.valid & (entry.tag == tag_q);
	// Zero on a miss
	assign ld_data  = ld_hit ? line[sel_q] : '0;

	// No loads until the arrays are cleared
	a_req_ready: assert property (@(posedge CLK) disable iff (!RST_N)
		ld_req |-> tag.ready)
		else $error("load request before cache ready");

endmodule

// ==== src/l1_ld_cache.sv ====
// --------------------
// L1 load path top level
// Tag and data arrays side by side plus lookup
// Fills write a full line, loads return one word
// --------------------
`timescale 1ns/1ps
`include "l1_ld_defs.svh"

module l1_ld_cache
	import l1_ld_pkg::*;
(
	input  logic                         CLK,
	input  logic                         RST_N,
	// Load side
	input  logic                         ld_req,
	input  logic [`L1_LD_ADDR_WIDTH-1:0] ld_addr,
	output logic                         ld_valid,
	output logic                         ld_hit,
	output logic [`L1_LD_WORD_WIDTH-1:0] ld_data,
	// Fill side
	input  logic                         fill_en,
	input  logic [`L1_LD_ADDR_WIDTH-1:0] fill_addr,
	input  logic [$bits(line_t)-1:0]     fill_line,
	// Status
	output logic                         ready
);

	ld_addr_t   ld_fields;
	ld_addr_t   fill_fields;
	tag_entry_t fill_entry;

	l1_ld_mem_if #(.WIDTH($bits(tag_entry_t)), .DEPTH(`L1_LD_DEPTH)) tag_if ();
	l1_ld_mem_if #(.WIDTH($bits(line_t)), .DEPTH(`L1_LD_DEPTH)) data_if ();

	// Split addresses into fields
	assign ld_fields   = ld_addr;
	assign fill_fields = fill_addr;

	// New entry is always valid
	assign fill_entry.valid = 1'b1;
	assign fill_entry.tag   = fill_fields.tag;

	// --------------------
	// Array ports
	// --------------------
	// Both arrays read at the load index
	assign tag_if.ren    = ld_req;
	assign tag_if.raddr  = ld_fields.index;
	assign data_if.ren   = ld_req;
	assign data_if.raddr = ld_fields.index;

	// Fills held off until both arrays are cleared
	assign tag_if.wen    = fill_en & ready;
	assign tag_if.waddr  = fill_fields.index;
	assign tag_if.wdata  = fill_entry;
	assign data_if.wen   = fill_en & ready;
	assign data_if.waddr = fill_fields.index;
	assign data_if.wdata = fill_line;

	assign ready = tag_if.ready & data_if.ready;

	l1_ld_dp_mem #(.WIDTH($bits(tag_entry_t)), .DEPTH(`L1_LD_DEPTH)) tag_mem (
		.CLK   (CLK),
		.RST_N (RST_N),
		.mem   (tag_if)
	);

	l1_ld_dp_mem #(.WIDTH($bits(line_t)), .DEPTH(`L1_LD_DEPTH)) data_mem (
		.CLK   (CLK),
		.RST_N (RST_N),
		.mem   (data_if)
	);

	// --------------------
	// Lookup stage
	// --------------------
	l1_ld_lookup lookup (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ld_req   (ld_req),
		.ld_addr  (ld_fields),
		.tag      (tag_if),
		.data     (data_if),
		.ld_valid (ld_valid),
		.ld_hit   (ld_hit),
		.ld_data  (ld_data)
	);

endmodule

// ==== test/l1_ld_tb.sv ====
// --------------------
// Testbench for the L1 load-side lookup path
// Replays fill and load records from the test data file
// Checks ready timing, hit flag, word and latency of each load
// --------------------
`timescale 1ns/1ps
`include "l1_ld_defs.svh"

module l1_ld_tb;

	localparam int LINE_W = `L1_LD_LINE_WORDS * `L1_LD_WORD_WIDTH;

	// One record of the data file
	typedef struct packed {
		logic [7:0]                   op;
		logic [`L1_LD_ADDR_WIDTH-1:0] addr;
		logic [LINE_W-1:0]            line;
		logic                         hit;
		logic [`L1_LD_WORD_WIDTH-1:0] word;
	} rec_t;

	// Load result still in flight
	typedef struct packed {
		logic [31:0]                  cycle;
		logic [7:0]                   test;
		logic                         hit;
		logic [`L1_LD_WORD_WIDTH-1:0] word;
	} exp_t;

	logic                         CLK;
	logic                         RST_N;
	logic                         ld_req;
	logic [`L1_LD_ADDR_WIDTH-1:0] ld_addr;
	logic                         ld_valid;
	logic                         ld_hit;
	logic [`L1_LD_WORD_WIDTH-1:0] ld_data;
	logic                         fill_en;
	logic [`L1_LD_ADDR_WIDTH-1:0] fill_addr;
	logic [LINE_W-1:0]            fill_line;
	logic                         ready;

	rec_t        recs[$];
	exp_t        exp_q[$];
	exp_t        got_exp;
	logic [31:0] cycle_count;
	logic [7:0]  cur_test;
	logic        loaded;

	l1_ld_cache uut (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ld_req    (ld_req),
		.ld_addr   (ld_addr),
		.ld_valid  (ld_valid),
		.ld_hit    (ld_hit),
		.ld_data   (ld_data),
		.fill_en   (fill_en),
		.fill_addr (fill_addr),
		.fill_line (fill_line),
		.ready     (ready)
	);

	// 40 ns period
	always #20 CLK = ~CLK;

	// --------------------
	// Helpers
	// --------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	function automatic string test_name(input logic [7:0] n);
		case (n)
			8'd1:    return "cold_miss";
			8'd2:    return "fill_words";
			8'd3:    return "tag_conflict";
			8'd4:    return "back_to_back";
			8'd5:    return "fill_then_load";
			default: return "unnamed";
		endcase
	endfunction

	// Whole file parsed up front and hash lines skipped
	task automatic load_records();
		int                           fd;
		int                           code;
		logic [7:0]                   op;
		logic [`L1_LD_ADDR_WIDTH-1:0] f_addr;
		logic [LINE_W-1:0]            f_line;
		logic                         f_hit;
		logic [`L1_LD_WORD_WIDTH-1:0] f_word;
		logic [8*160-1:0]             rest;
		rec_t                         r;
		fd = $fopen("test/l1_ld_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("could not open test/l1_ld_testdata.txt");
		end else begin
			code = $fscanf(fd, " %c", op);
			while (code == 1) begin
				r = '0;
				r.op = op;
				case (op)
					"#": code = $fgets(rest, fd);
					"T": begin
						code = $fscanf(fd, "%h", f_addr);
						r.addr = f_addr;
						recs.push_back(r);
					end
					"F": begin
						code = $fscanf(fd, "%h %h", f_addr, f_line);
						r.addr = f_addr;
						r.line = f_line;
						recs.push_back(r);
					end
					"L": begin
						code = $fscanf(fd, "%h %h %h", f_addr, f_hit, f_word);
						r.addr = f_addr;
						r.hit  = f_hit;
						r.word = f_word;
						recs.push_back(r);
					end
					default: abort_run("unknown record type in test data file");
				endcase
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------
	// Each call runs from 2 ns after one edge to 2 ns after the next
	task automatic issue_fill(input rec_t r);
		fill_en   = 1'b1;
		fill_addr = r.addr;
		fill_line = r.line;
		@(posedge CLK);
		#2;
		fill_en   = 1'b0;
	endtask

	task automatic issue_load(input rec_t r);
		exp_t e;
		ld_req  = 1'b1;
		ld_addr = r.addr;
		// Result shows right after the edge that samples the request
		e.cycle = cycle_count + 1;
		e.test  = cur_test;
		e.hit   = r.hit;
		e.word  = r.word;
		exp_q.push_back(e);
		@(posedge CLK);
		#2;
		ld_req  = 1'b0;
	endtask

	initial begin
		CLK       = 1'b0;
		RST_N     = 1'b0;
		ld_req    = 1'b0;
		ld_addr   = '0;
		fill_en   = 1'b0;
		fill_addr = '0;
		fill_line = '0;
		cur_test  = '0;
		loaded    = 1'b0;
		load_records();
		loaded = 1'b1;
		repeat (5) @(posedge CLK);
		#2;
		check_value("reset ready", 32'd0, 32'(ready));
		check_value("reset ld_valid", 32'd0, 32'(ld_valid));
		check_value("reset ld_hit", 32'd0, 32'(ld_hit));
		RST_N = 1'b1;
		// Ready stays low until the 64th edge of the clear sweep
		for (int i = 1; i <= `L1_LD_DEPTH; i++) begin
			@(posedge CLK);
			#1;
			check_value($sformatf("ready_ramp edge %0d", i), 32'(i == `L1_LD_DEPTH),
				32'(ready));
		end
		#1;
		foreach (recs[i]) begin
			case (recs[i].op)
				"T":     cur_test = recs[i].addr[7:0];
				"F":     issue_fill(recs[i]);
				default: issue_load(recs[i]);
			endcase
		end
		// Drain results still in flight
		while (exp_q.size() != 0) begin
			@(posedge CLK);
			#2;
		end
		repeat (2) @(posedge CLK);
		$display("sim passed");
		$finish;
	end

	// --------------------
	// Result monitor
	// --------------------
	always begin
		@(posedge CLK);
		#1;
		cycle_count = cycle_count + 1;
		if (ld_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("load result seen with no load outstanding");
			end else begin
				got_exp = exp_q.pop_front();
				check_value({test_name(got_exp.test), " cycle"}, got_exp.cycle, cycle_count);
				check_value({test_name(got_exp.test), " hit"}, 32'(got_exp.hit), 32'(ld_hit));
				check_value({test_name(got_exp.test), " data"}, got_exp.word, ld_data);
			end
		end else if (exp_q.size() != 0 && exp_q[0].cycle <= cycle_count) begin
			abort_run($sformatf("%s load result missing in cycle %0d",
				test_name(exp_q[0].test), cycle_count));
		end
	end

	initial begin
		cycle_count = '0;
	end

	// Reset and clear sweep plus one cycle per record and a margin
	initial begin
		int limit;
		wait (loaded);
		limit = 5 + `L1_LD_DEPTH + recs.size() + 100;
		#(40 * limit);
		abort_run($sformatf("timeout, run did not finish within %0d cycles", limit));
	end

endmodule

// ==== test/l1_ld_testdata.txt ====
# Records: T test_no | F addr line(hex, word 3 first) | L addr exp_hit exp_word
# Address hex: tag [31:10], index [9:4], offset [3:0]
T 1
L 00000000 0 00000000
L 00001230 0 00000000
L fffffff0 0 00000000
T 2
F 00012340 a3a3a3a3b2b2b2b2c1c1c1c1d0d0d0d0
L 00012340 1 d0d0d0d0
L 00012344 1 c1c1c1c1
L 0001234b 1 b2b2b2b2
L 0001234f 1 a3a3a3a3
T 3
L 00012744 0 00000000
F 00012740 0f0f0f0f1e1e1e1e2d2d2d2d3c3c3c3c
L 00012748 1 1e1e1e1e
L 00012340 0 00000000
T 4
F 00000100 40000003400000024000000140000000
F 00000230 50000003500000025000000150000000
L 00000108 1 40000002
L 00000234 1 50000001
L 00000310 0 00000000
L 0000010c 1 40000003
T 5
F abcde5f0 deadbeefcafef00d0123456789abcdef
L abcde5f8 1 cafef00d

// ==== verilog.f ====
+incdir+include
src/l1_ld_pkg.sv
src/l1_ld_mem_if.sv
src/sram_dp.sv
src/l1_ld_dp_mem.sv
src/l1_ld_lookup.sv
src/l1_ld_cache.sv
test/l1_ld_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the L1 load path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module l1_ld_tb \
	-f verilog.f -o l1_ld_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/l1_ld_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
